// ==== net_perf_top.f ====
design/net_perf_pkg.sv
design/mac_event_if.sv
design/phy_reset_hold.sv
design/mac_perf_counters.sv
design/perf_port_readout.sv
design/perf_readout_mux.sv
design/net_perf_top.sv
tb/net_perf_top_assert.sv
tb/tb_net_perf_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the net_perf_top testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=sim_net_perf

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_net_perf_top \
	-f net_perf_top.f \
	-Mdir "$OBJ_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Let the testbench see every checker error before it stops the run
"./$OBJ_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

exit 0

// ==== tb/tb_net_perf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_net_perf_top;

	localparam int NUM_PORTS      = 4;
	localparam int PHY_RST_CYCLES = 64;
	localparam int PORT_BITS      = 2;
	localparam int CW             = net_perf_pkg::CTR_WIDTH;
	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 3;

	// Phase lengths in cycles
	localparam int NUM_SWEEP_IDS   = 7;
	localparam int SWEEP_CYCLES    = NUM_PORTS * NUM_SWEEP_IDS;
	localparam int RANDOM_CYCLES   = 600;
	localparam int DIRECTED_CYCLES = 16;
	localparam int DRAIN_CYCLES    = 4;
	localparam int STIM_CYCLES     = RESET_CYCLES + PHY_RST_CYCLES + 2 * SWEEP_CYCLES
		+ RANDOM_CYCLES + DIRECTED_CYCLES + DRAIN_CYCLES;
	localparam int WATCHDOG_CYCLES = STIM_CYCLES + 200;

	localparam logic [31:0] SEED = 32'h5fa6109c;

	logic                                     clk_125mhz = 1'b0;
	logic                                     rst;
	logic [NUM_PORTS-1:0]                     rx_commit;
	logic [NUM_PORTS-1:0]                     rx_drop;
	net_perf_pkg::frame_len_t [NUM_PORTS-1:0] rx_len;
	logic [NUM_PORTS-1:0]                     tx_commit;
	net_perf_pkg::frame_len_t [NUM_PORTS-1:0] tx_len;
	logic                                     perf_rd;
	logic [PORT_BITS-1:0]                     perf_rd_port;
	logic [net_perf_pkg::REGID_WIDTH-1:0]     perf_regid;
	logic                                     perf_valid;
	logic [CW-1:0]                            perf_value;
	logic                                     phy_rst_n;

	bit done          = 1'b0;
	bit fail_reported = 1'b0;

	// 125 MHz
	always #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;

	net_perf_top #(
		.NUM_PORTS(NUM_PORTS),
		.PHY_RST_CYCLES(PHY_RST_CYCLES)
	) i_dut (
		.clk_125mhz(clk_125mhz),
		.rst(rst),
		.rx_commit(rx_commit),
		.rx_drop(rx_drop),
		.rx_len(rx_len),
		.tx_commit(tx_commit),
		.tx_len(tx_len),
		.perf_rd(perf_rd),
		.perf_rd_port(perf_rd_port),
		.perf_regid(perf_regid),
		.perf_valid(perf_valid),
		.perf_value(perf_value),
		.phy_rst_n(phy_rst_n)
	);

	////////////////////////////////////////
	// Stimulus helpers

	// Inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk_125mhz);
		#1;
	endtask

	task automatic idle_inputs();
		rx_commit    = '0;
		rx_drop      = '0;
		tx_commit    = '0;
		rx_len       = '0;
		tx_len       = '0;
		perf_rd      = 1'b0;
		perf_rd_port = '0;
		perf_regid   = '0;
	endtask

	// Each strobe fires with pct percent chance, lengths 64 to 1518
	task automatic random_events(input int pct);
		for (int p = 0; p < NUM_PORTS; p++) begin
			rx_commit[p] = (($urandom % 100) < pct);
			rx_drop[p]   = (($urandom % 100) < pct);
			tx_commit[p] = (($urandom % 100) < pct);
			rx_len[p]    = 16'(64 + ($urandom % 1455));
			tx_len[p]    = 16'(64 + ($urandom % 1455));
		end
	endtask

	task automatic issue_read(input int port, input logic [15:0] regid);
		perf_rd      = 1'b1;
		perf_rd_port = PORT_BITS'(port);
		perf_regid   = regid;
	endtask

	// Every port and id back to back, ids 5 and 6 unknown
	task automatic sweep_reads();
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int id = 0; id < NUM_SWEEP_IDS; id++) begin
				issue_read(p, 16'(id));
				next_cycle();
			end
		end
		perf_rd = 1'b0;
	endtask

	task automatic abort_run(input string why);
		fail_reported = 1'b1;
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		idle_inputs();
		repeat (RESET_CYCLES) @(posedge clk_125mhz);
		#1;
		rst = 1'b0;

		// Hold-off runs out, watchdog bounds the wait
		while (phy_rst_n !== 1'b1)
			next_cycle();

		// All counters still zero
		sweep_reads();

		// Random traffic with interleaved reads, often back to back
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			random_events(30);
			if (($urandom % 3) == 0) begin
				if (($urandom % 16) == 0)
					issue_read(int'($urandom % NUM_PORTS), 16'hffff);
				else
					issue_read(int'($urandom % NUM_PORTS), 16'($urandom % 6));
			end else begin
				perf_rd = 1'b0;
			end
			next_cycle();
		end
		idle_inputs();

		// Commit and drop together on every port
		rx_commit = '1;
		rx_drop   = '1;
		tx_commit = '1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			rx_len[p] = 16'(100 + p);
			tx_len[p] = 16'(200 + p);
		end
		next_cycle();
		idle_inputs();

		// One read per port on consecutive cycles
		for (int p = 0; p < NUM_PORTS; p++) begin
			issue_read(p, net_perf_pkg::REG_RX_BYTES);
			next_cycle();
		end
		for (int p = NUM_PORTS - 1; p >= 0; p--) begin
			issue_read(p, net_perf_pkg::REG_RX_DROPS);
			next_cycle();
		end
		issue_read(0, 16'h0005);
		next_cycle();
		issue_read(1, 16'hffff);
		next_cycle();
		idle_inputs();

		sweep_reads();

		// Last responses out
		repeat (DRAIN_CYCLES) next_cycle();
		while (perf_valid)
			next_cycle();

		if (i_dut.i_assert.err_count == 0) begin
			done = 1'b1;
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run("checker reported errors during the run");
		end
	end

	// Stop at the first checker error
	always @(negedge clk_125mhz) begin
		if (i_dut.i_assert.err_count != 0)
			abort_run("checker assertion failed, see error above");
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before the test finished");
	end

	final begin
		if (!done && !fail_reported)
			$display("Test failed");
	end

endmodule

`default_nettype wire

// ==== tb/net_perf_top_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_perf_top_assert #(
	parameter int NUM_PORTS      = 4,
	parameter int PHY_RST_CYCLES = 64,
	localparam int PORT_BITS     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
)(
	input logic                                     clk_125mhz,
	input logic                                     rst,
	input logic [NUM_PORTS-1:0]                     rx_commit,
	input logic [NUM_PORTS-1:0]                     rx_drop,
	input net_perf_pkg::frame_len_t [NUM_PORTS-1:0] rx_len,
	input logic [NUM_PORTS-1:0]                     tx_commit,
	input net_perf_pkg::frame_len_t [NUM_PORTS-1:0] tx_len,
	input logic                                     perf_rd,
	input logic [PORT_BITS-1:0]                     perf_rd_port,
	input logic [net_perf_pkg::REGID_WIDTH-1:0]     perf_regid,
	input logic                                     perf_valid,
	input logic [net_perf_pkg::CTR_WIDTH-1:0]       perf_value,
	input logic                                     phy_rst_n
);

	localparam int CW       = net_perf_pkg::CTR_WIDTH;
	localparam int NUM_REGS = 5;

	// Register ids of the counter map
	localparam int ID_RX_FRAMES = 0;
	localparam int ID_RX_DROPS  = 1;
	localparam int ID_RX_BYTES  = 2;
	localparam int ID_TX_FRAMES = 3;
	localparam int ID_TX_BYTES  = 4;

	// Failed checks so far, watched by the testbench
	int err_count = 0;

	logic [CW-1:0] shadow [NUM_PORTS][NUM_REGS];

	// Two-deep expected read pipeline
	logic          exp_valid_q1;
	logic          exp_valid_q2;
	logic [CW-1:0] exp_value_q1;
	logic [CW-1:0] exp_value_q2;

	// Cycles since reset went away, saturating
	int            rel_cycles;
	logic          rst_q;

	// Counter value a read of this port and id should return
	function automatic logic [CW-1:0] expected_value(input logic [PORT_BITS-1:0] port,
		input logic [net_perf_pkg::REGID_WIDTH-1:0] regid);
		if (regid < 16'(NUM_REGS))
			return shadow[port][regid[2:0]];
		// Unknown id
		return '0;
	endfunction

	////////////////////////////////////////
	// Shadow model

	// Rebuilt from the top-level strobes only
	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			for (int p = 0; p < NUM_PORTS; p++)
				for (int r = 0; r < NUM_REGS; r++)
					shadow[p][r] <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (rx_commit[p]) begin
					shadow[p][ID_RX_FRAMES] <= shadow[p][ID_RX_FRAMES] + CW'(1);
					shadow[p][ID_RX_BYTES]  <= shadow[p][ID_RX_BYTES] + CW'(rx_len[p]);
				end
				// Drops count frames, never bytes
				if (rx_drop[p])
					shadow[p][ID_RX_DROPS] <= shadow[p][ID_RX_DROPS] + CW'(1);
				if (tx_commit[p]) begin
					shadow[p][ID_TX_FRAMES] <= shadow[p][ID_TX_FRAMES] + CW'(1);
					shadow[p][ID_TX_BYTES]  <= shadow[p][ID_TX_BYTES] + CW'(tx_len[p]);
				end
			end
		end
	end

	// Read seen at edge N is due after edge N+1
	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			exp_valid_q1 <= 1'b0;
			exp_valid_q2 <= 1'b0;
		end else begin
			exp_valid_q1 <= perf_rd && (int'(perf_rd_port) < NUM_PORTS);
			exp_valid_q2 <= exp_valid_q1;
		end
		exp_value_q1 <= expected_value(perf_rd_port, perf_regid);
		exp_value_q2 <= exp_value_q1;
	end

	always_ff @(posedge clk_125mhz) begin
		rst_q <= rst;
		if (rst)
			rel_cycles <= 0;
		else if (rel_cycles < PHY_RST_CYCLES)
			rel_cycles <= rel_cycles + 1;
	end

	////////////////////////////////////////
	// Checks

	// PHY kept in reset right after any reset cycle
	a_phy_in_reset: assert property (@(posedge clk_125mhz) rst_q |-> !phy_rst_n)
	else begin
		err_count++;
		$error("mismatch at %0t: phy_rst_n high during reset", $time);
	end

	// Release exactly PHY_RST_CYCLES after reset, then held
	a_phy_release: assert property (@(posedge clk_125mhz) disable iff (rst)
		phy_rst_n == (rel_cycles >= PHY_RST_CYCLES))
	else begin
		err_count++;
		$error("mismatch at %0t: phy_rst_n %0b after %0d cycles", $time,
			$sampled(phy_rst_n), $sampled(rel_cycles));
	end

	a_valid_timing: assert property (@(posedge clk_125mhz) disable iff (rst)
		perf_valid == exp_valid_q2)
	else begin
		err_count++;
		$error("mismatch at %0t: perf_valid %0b expected %0b", $time,
			$sampled(perf_valid), $sampled(exp_valid_q2));
	end

	a_value: assert property (@(posedge clk_125mhz) disable iff (rst)
		exp_valid_q2 |-> perf_value == exp_value_q2)
	else begin
		err_count++;
		$error("mismatch at %0t: perf_value %0h expected %0h", $time,
			$sampled(perf_value), $sampled(exp_value_q2));
	end

endmodule

bind net_perf_top net_perf_top_assert #(
	.NUM_PORTS(NUM_PORTS),
	.PHY_RST_CYCLES(PHY_RST_CYCLES)
) i_assert (
	.clk_125mhz(clk_125mhz),
	.rst(rst),
	.rx_commit(rx_commit),
	.rx_drop(rx_drop),
	.rx_len(rx_len),
	.tx_commit(tx_commit),
	.tx_len(tx_len),
	.perf_rd(perf_rd),
	.perf_rd_port(perf_rd_port),
	.perf_regid(perf_regid),
	.perf_valid(perf_valid),
	.perf_value(perf_value),
	.phy_rst_n(phy_rst_n)
);

`default_nettype wire

// ==== design/net_perf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module net_perf_top #(
	parameter int NUM_PORTS      = 4,
	parameter int PHY_RST_CYCLES = 2**19,
	localparam int PORT_BITS     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
)(
	input  logic                                               clk_125mhz,
	input  logic                                               rst,

	////////////////////////////////////////
	// MAC frame events, one lane per port

	input  logic [NUM_PORTS-1:0]                               rx_commit,
	input  logic [NUM_PORTS-1:0]                               rx_drop,
	input  net_perf_pkg::frame_len_t [NUM_PORTS-1:0]           rx_len,
	input  logic [NUM_PORTS-1:0]                               tx_commit,
	input  net_perf_pkg::frame_len_t [NUM_PORTS-1:0]           tx_len,

	////////////////////////////////////////
	// Performance counter access

	input  logic                                               perf_rd,
	input  logic [PORT_BITS-1:0]                               perf_rd_port,
	input  logic [net_perf_pkg::REGID_WIDTH-1:0]               perf_regid,
	output logic                                               perf_valid,
	output logic [net_perf_pkg::CTR_WIDTH-1:0]                 perf_value,

	// PHY reset, active low
	output logic                                               phy_rst_n
);

	// Per-port responses into the output mux
	logic [NUM_PORTS-1:0]                              rd_valids;
	logic [NUM_PORTS-1:0][net_perf_pkg::CTR_WIDTH-1:0] rd_values;

	////////////////////////////////////////
	// PHY reset hold-off

	phy_reset_hold #(
		.PHY_RST_CYCLES(PHY_RST_CYCLES)
	) i_phy_reset_hold (
		.clk_125mhz(clk_125mhz),
		.rst(rst),
		.phy_rst_n(phy_rst_n)
	);

	////////////////////////////////////////
	// Per-port counters and readout

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port

		mac_event_if ev_if ();

		net_perf_pkg::mac_perf_t counters;

		// Flat top-level lanes into the event bundle
		assign ev_if.rx_commit = rx_commit[g];
		assign ev_if.rx_drop   = rx_drop[g];
		assign ev_if.rx_len    = rx_len[g];
		assign ev_if.tx_commit = tx_commit[g];
		assign ev_if.tx_len    = tx_len[g];

		mac_perf_counters i_counters (
			.clk_125mhz(clk_125mhz),
			.rst(rst),
			.ev(ev_if.dst),
			.counters(counters)
		);

		// Raw id goes in as the enum, unknown ids decode to zero
		perf_port_readout #(
			.NUM_PORTS(NUM_PORTS),
			.PORT_INDEX(g)
		) i_readout (
			.clk_125mhz(clk_125mhz),
			.rst(rst),
			.perf_rd(perf_rd),
			.perf_rd_port(perf_rd_port),
			.perf_regid(net_perf_pkg::perf_reg_e'(perf_regid)),
			.counters(counters),
			.rd_valid(rd_valids[g]),
			.rd_data(rd_values[g])
		);

	end

	////////////////////////////////////////
	// Output mux

	perf_readout_mux #(
		.NUM_PORTS(NUM_PORTS)
	) i_readout_mux (
		.clk_125mhz(clk_125mhz),
		.rst(rst),
		.rd_valids(rd_valids),
		.rd_values(rd_values),
		.perf_valid(perf_valid),
		.perf_value(perf_value)
	);

endmodule

`default_nettype wire

// ==== design/perf_readout_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_readout_mux #(
	parameter int NUM_PORTS = 4
)(
	input  logic                                              clk_125mhz,
	input  logic                                              rst,

	// Per-port responses, at most one valid per cycle
	input  logic [NUM_PORTS-1:0]                              rd_valids,
	input  logic [NUM_PORTS-1:0][net_perf_pkg::CTR_WIDTH-1:0] rd_values,

	// Management output
	output logic                                              perf_valid,
	output logic [net_perf_pkg::CTR_WIDTH-1:0]                perf_value
);

	////////////////////////////////////////
	// Output stage

	always_ff @(posedge clk_125mhz) begin
		if (rst)
			perf_valid <= 1'b0;
		else
			perf_valid <= |rd_valids;
	end

	// Take the value of whichever port answered
	// Holds last value when nobody answers
	always_ff @(posedge clk_125mhz) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (rd_valids[i])
				perf_value <= rd_values[i];
		end
	end

endmodule

`default_nettype wire

// ==== design/perf_port_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_port_readout #(
	parameter int NUM_PORTS  = 4,
	parameter int PORT_INDEX = 0,
	localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
)(
	input  logic                               clk_125mhz,
	input  logic                               rst,

	// Management read request
	input  logic                               perf_rd,
	input  logic [PORT_BITS-1:0]               perf_rd_port,
	input  net_perf_pkg::perf_reg_e            perf_regid,

	// Live counters of this port
	input  net_perf_pkg::mac_perf_t            counters,

	// One-cycle response
	output logic                               rd_valid,
	output logic [net_perf_pkg::CTR_WIDTH-1:0] rd_data
);

	logic                               port_hit;
	logic [net_perf_pkg::CTR_WIDTH-1:0] sel_value;

	// Port decode, only place it happens
	assign port_hit = perf_rd && (perf_rd_port == PORT_BITS'(PORT_INDEX));

	// Register id decode
	always_comb begin
		case (perf_regid)
			net_perf_pkg::REG_RX_FRAMES: sel_value = counters.rx_frames;
			net_perf_pkg::REG_RX_DROPS:  sel_value = counters.rx_drops;
			net_perf_pkg::REG_RX_BYTES:  sel_value = counters.rx_bytes;
			net_perf_pkg::REG_TX_FRAMES: sel_value = counters.tx_frames;
			net_perf_pkg::REG_TX_BYTES:  sel_value = counters.tx_bytes;
			// Unknown id
			default:                     sel_value = '0;
		endcase
	end

	////////////////////////////////////////
	// Response register

	always_ff @(posedge clk_125mhz) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= port_hit;
	end

	// Latched snapshot, held between reads
	always_ff @(posedge clk_125mhz) begin
		if (port_hit)
			rd_data <= sel_value;
	end

endmodule

`default_nettype wire

// ==== design/mac_perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_perf_counters (
	input  logic                   clk_125mhz,
	input  logic                   rst,
	mac_event_if.dst               ev,
	output net_perf_pkg::mac_perf_t counters
);

	localparam int CW = net_perf_pkg::CTR_WIDTH;
	localparam int LW = $bits(net_perf_pkg::frame_len_t);

	// Lengths widened to counter width
	logic [CW-1:0] rx_len_ext;
	logic [CW-1:0] tx_len_ext;

	assign rx_len_ext = {{(CW-LW){1'b0}}, ev.rx_len};
	assign tx_len_ext = {{(CW-LW){1'b0}}, ev.tx_len};

	////////////////////////////////////////
	// RX side

	// Commit and drop may land together, each counts on its own
	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			counters.rx_frames <= '0;
			counters.rx_drops  <= '0;
			counters.rx_bytes  <= '0;
		end else begin
			if (ev.rx_commit) begin
				counters.rx_frames <= counters.rx_frames + 1'b1;
				// Only committed frames add bytes
				counters.rx_bytes  <= counters.rx_bytes + rx_len_ext;
			end
			// Dropped frames count, their bytes do not
			if (ev.rx_drop)
				counters.rx_drops <= counters.rx_drops + 1'b1;
		end
	end

	////////////////////////////////////////
	// TX side

	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			counters.tx_frames <= '0;
			counters.tx_bytes  <= '0;
		end else if (ev.tx_commit) begin
			counters.tx_frames <= counters.tx_frames + 1'b1;
			counters.tx_bytes  <= counters.tx_bytes + tx_len_ext;
		end
	end

	// 64 bits at 125 MHz never wraps in practice, no saturation logic

endmodule

`default_nettype wire

// ==== design/phy_reset_hold.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_reset_hold #(
	parameter int PHY_RST_CYCLES = 2**19
)(
	input  logic clk_125mhz,
	input  logic rst,
	output logic phy_rst_n
);

	// Wide enough for PHY_RST_CYCLES-1
	localparam int CNT_WIDTH = (PHY_RST_CYCLES > 1) ? $clog2(PHY_RST_CYCLES) : 1;

	logic [CNT_WIDTH-1:0] hold_count;

	////////////////////////////////////////
	// Hold-off counter

	// Long hold so strap pins settle before the PHYs leave reset
	// Counter reloads on every reset, then counts down to zero and parks
	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			hold_count <= CNT_WIDTH'(PHY_RST_CYCLES - 1);
			phy_rst_n  <= 1'b0;
		end else if (hold_count == '0) begin
			// Release and stay released until next reset
			phy_rst_n <= 1'b1;
		end else begin
			hold_count <= hold_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/mac_event_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mac_event_if;

	// RX frame committed to the buffer
	logic                    rx_commit;
	// RX frame dropped
	logic                    rx_drop;
	// Length for either RX strobe, valid with the strobe
	net_perf_pkg::frame_len_t rx_len;

	// TX frame sent
	logic                    tx_commit;
	// Length of the sent frame
	net_perf_pkg::frame_len_t tx_len;

	// MAC side drives the strobes
	modport src (
		output rx_commit, rx_drop, rx_len,
		output tx_commit, tx_len
	);

	// Counter side only samples
	modport dst (
		input rx_commit, rx_drop, rx_len,
		input tx_commit, tx_len
	);

endinterface

`default_nettype wire

// ==== design/net_perf_pkg.sv ====
`default_nettype none

package net_perf_pkg;

	////////////////////////////////////////
	// Widths

	// One management word per counter
	localparam int CTR_WIDTH = 64;

	// Register id width on the management side
	localparam int REGID_WIDTH = 16;

	// Frame length in bytes
	typedef logic [15:0] frame_len_t;

	////////////////////////////////////////
	// Register map

	// Ids not listed here read back as zero
	typedef enum logic [REGID_WIDTH-1:0] {
		REG_RX_FRAMES = 16'd0,
		REG_RX_DROPS  = 16'd1,
		REG_RX_BYTES  = 16'd2,
		REG_TX_FRAMES = 16'd3,
		REG_TX_BYTES  = 16'd4
	} perf_reg_e;

	////////////////////////////////////////
	// Counter set

	// Full counter set of one MAC port
	typedef struct packed {
		// Frames accepted by the RX path
		logic [CTR_WIDTH-1:0] rx_frames;
		// Frames discarded by the RX path
		logic [CTR_WIDTH-1:0] rx_drops;
		// Bytes of accepted frames only
		logic [CTR_WIDTH-1:0] rx_bytes;
		// Frames sent
		logic [CTR_WIDTH-1:0] tx_frames;
		// Bytes of sent frames
		logic [CTR_WIDTH-1:0] tx_bytes;
	} mac_perf_t;

endpackage

`default_nettype wire
